/* hw/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  localparam int DATA_W  = 64;
  localparam int HALF_W  = 32;
  localparam int FLAGS_W = 6;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_mov,
    op_zxt8,
    op_zxt16,
    op_sxt8,
    op_sxt16,
    op_sxt32,
    op_cmov,
    op_cset,
    op_csand,
    op_csor
  } alu_op_e;

  // x86 condition codes, base form then its inverse
  typedef enum logic [3:0] {
    z,
    nz,
    s,
    ns,
    ugt,
    ule,
    uge,
    ult,
    sgt,
    sle,
    sge,
    slt,
    o,
    no,
    p,
    np
  } cond_e;

  // C-O-A-S-Z-P, carry in the msb
  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  typedef struct packed {
    alu_op_e           op;
    logic              wide;       // 64-bit form
    cond_e             cond;
    logic              set_flags;
    logic              thread;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } alu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] result;
    flags_t            flags;
    logic              set_flags;
  } alu_resp_t;

  typedef struct packed {
    logic hit;
    logic thread;
  } except_t;

  typedef struct packed {
    logic [DATA_W-1:0] sum;
    logic              c64;
    logic              c32;
    logic              c4;   // aux carry source
    logic              o64;
    logic              o32;
  } adder_out_t;

endpackage

`default_nettype wire

/* hw/alu_adder.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_adder
  import alu_pkg::*;
(
  input  alu_req_t   req,
  output adder_out_t sum
);

  logic                   is_sub;
  logic [DATA_W-1:0]      b_in;
  logic [4:0]             lo_nib;   // bits 3:0 and carry out
  logic [HALF_W-4:0]      mid;      // bits 31:4 and carry out
  logic [DATA_W-HALF_W:0] hi;       // bits 63:32 and carry out
  logic [DATA_W-1:0]      sum_w;

  assign is_sub = (req.op == op_sub);

  // subtract as a + ~b + 1
  assign b_in = is_sub ? ~req.b : req.b;

  // split chain so the nibble and half-word carries are visible
  assign lo_nib = {1'b0, req.a[3:0]} + {1'b0, b_in[3:0]} + {4'b0, is_sub};

  assign mid = {1'b0, req.a[HALF_W-1:4]} + {1'b0, b_in[HALF_W-1:4]}
             + {{(HALF_W-4){1'b0}}, lo_nib[4]};

  assign hi = {1'b0, req.a[DATA_W-1:HALF_W]} + {1'b0, b_in[DATA_W-1:HALF_W]}
            + {{(DATA_W-HALF_W){1'b0}}, mid[HALF_W-4]};

  assign sum_w = {hi[DATA_W-HALF_W-1:0], mid[HALF_W-5:0], lo_nib[3:0]};

  always_comb begin
    sum     = '0;
    sum.sum = sum_w;
    sum.c4  = lo_nib[4];
    sum.c32 = mid[HALF_W-4];
    sum.c64 = hi[DATA_W-HALF_W];
    // overflow when both addends agree in sign and the sum does not
    sum.o64 = (req.a[DATA_W-1] == b_in[DATA_W-1]) &&
              (sum_w[DATA_W-1] != req.a[DATA_W-1]);
    sum.o32 = (req.a[HALF_W-1] == b_in[HALF_W-1]) &&
              (sum_w[HALF_W-1] != req.a[HALF_W-1]);
  end

endmodule

`default_nettype wire

/* hw/alu_cond_eval.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_cond_eval
  import alu_pkg::*;
(
  input  flags_t flags,
  input  cond_e  cond,
  output logic   taken
);

  logic below_eq;   // unsigned
  logic less;       // signed
  logic less_eq;

  assign below_eq = flags.c | flags.z;
  assign less     = flags.s ^ flags.o;
  assign less_eq  = less | flags.z;

  always_comb begin
    taken = 1'b0;
    case (cond)
      z:   taken = flags.z;
      nz:  taken = ~flags.z;
      s:   taken = flags.s;
      ns:  taken = ~flags.s;
      ugt: taken = ~below_eq;
      ule: taken = below_eq;
      uge: taken = ~flags.c;
      ult: taken = flags.c;
      sgt: taken = ~less_eq;
      sle: taken = less_eq;
      sge: taken = ~less;
      slt: taken = less;
      o:   taken = flags.o;
      no:  taken = ~flags.o;
      p:   taken = flags.p;
      np:  taken = ~flags.p;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/alu_logic_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_logic_unit
  import alu_pkg::*;
(
  input  alu_req_t          req,
  input  logic              taken,
  output logic [DATA_W-1:0] result
);

  logic [DATA_W-1:0] and_w;
  logic [DATA_W-1:0] or_w;
  logic [DATA_W-1:0] xor_w;
  logic [DATA_W-1:0] sel_w;
  logic [DATA_W-1:0] zxt8_w;
  logic [DATA_W-1:0] zxt16_w;
  logic [DATA_W-1:0] sxt8_w;
  logic [DATA_W-1:0] sxt16_w;
  logic [DATA_W-1:0] sxt32_w;
  logic              bit_and;
  logic              bit_or;

  // 32-bit forms clear the upper half
  function automatic logic [DATA_W-1:0] fit(input logic [DATA_W-1:0] v,
                                            input logic              wide);
    if (wide) begin
      fit = v;
    end else begin
      fit = {{(DATA_W-HALF_W){1'b0}}, v[HALF_W-1:0]};
    end
  endfunction

  assign and_w = req.a & req.b;
  assign or_w  = req.a | req.b;
  assign xor_w = req.a ^ req.b;

  assign sel_w = taken ? req.b : req.a;   // cmov

  // extends take their source from b
  assign zxt8_w  = {{(DATA_W-8){1'b0}}, req.b[7:0]};
  assign zxt16_w = {{(DATA_W-16){1'b0}}, req.b[15:0]};

  // full sign fill, narrowed afterwards by fit
  assign sxt8_w  = {{(DATA_W-8){req.b[7]}}, req.b[7:0]};
  assign sxt16_w = {{(DATA_W-16){req.b[15]}}, req.b[15:0]};
  assign sxt32_w = {{(DATA_W-HALF_W){req.b[HALF_W-1]}}, req.b[HALF_W-1:0]};

  assign bit_and = taken & req.a[0];
  assign bit_or  = taken | req.a[0];

  always_comb begin
    result = '0;
    case (req.op)
      op_and:   result = fit(and_w, req.wide);
      op_or:    result = fit(or_w, req.wide);
      op_xor:   result = fit(xor_w, req.wide);
      op_mov:   result = fit(req.b, req.wide);
      op_zxt8:  result = zxt8_w;
      op_zxt16: result = zxt16_w;
      op_sxt8:  result = fit(sxt8_w, req.wide);
      op_sxt16: result = fit(sxt16_w, req.wide);
      op_sxt32: result = fit(sxt32_w, req.wide);
      op_cmov:  result = fit(sel_w, req.wide);
      op_cset:  result = {{(DATA_W-1){1'b0}}, taken};
      op_csand: result = {{(DATA_W-1){1'b0}}, bit_and};
      op_csor:  result = {{(DATA_W-1){1'b0}}, bit_or};
      default:  result = '0;   // add and sub come from the adder
    endcase
  end

endmodule

`default_nettype wire

/* hw/alu_retire.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_retire
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  alu_req_t          req,
  input  logic [DATA_W-1:0] result,
  input  adder_out_t        sum,
  input  except_t           exc,
  output logic              out_valid,
  output alu_resp_t         out_resp
);

  except_t           exc_q;
  logic              cancel;
  logic              is_arith;
  logic              is_logic;
  logic              is_sub;
  flags_t            terms_d;   // raw, before borrow inversion
  flags_t            terms_q;
  logic              valid_q;
  logic              arith_q;
  logic              logic_q;
  logic              sub_q;
  logic              set_q;
  logic [DATA_W-1:0] result_q;
  logic [FLAGS_W-1:0] flag_word;

  // exception now or one edge earlier on the same thread kills the op
  assign cancel = (exc.hit && (exc.thread == req.thread)) ||
                  (exc_q.hit && (exc_q.thread == req.thread));

  assign is_sub   = (req.op == op_sub);
  assign is_arith = (req.op == op_add) || is_sub;
  assign is_logic = (req.op == op_and) || (req.op == op_or) || (req.op == op_xor);

  always_comb begin
    terms_d   = '0;
    terms_d.c = req.wide ? sum.c64 : sum.c32;
    terms_d.o = req.wide ? sum.o64 : sum.o32;
    terms_d.a = sum.c4;
    terms_d.s = req.wide ? result[DATA_W-1] : result[HALF_W-1];
    if (req.wide) begin
      terms_d.z = (result == '0);
    end else begin
      terms_d.z = (result[HALF_W-1:0] == '0);
    end
    terms_d.p = ~^result[7:0];   // even parity, low byte only
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exc_q    <= '0;
      valid_q  <= 1'b0;
      arith_q  <= 1'b0;
      logic_q  <= 1'b0;
      set_q    <= 1'b0;
      result_q <= '0;
    end else begin
      exc_q    <= exc;
      valid_q  <= in_valid && !cancel;
      arith_q  <= is_arith;
      logic_q  <= is_logic;
      set_q    <= req.set_flags && (is_arith || is_logic);
      result_q <= result;
    end
  end

  always_ff @(posedge clk) begin
    terms_q <= terms_d;
    sub_q   <= is_sub;
  end

  // flag mux on the registered terms
  always_comb begin
    flag_word = '0;
    if (arith_q) begin
      flag_word = {terms_q.c ^ sub_q,   // borrow for sub
                   terms_q.o,
                   terms_q.a ^ sub_q,
                   terms_q.s,
                   terms_q.z,
                   terms_q.p};
    end else if (logic_q) begin
      flag_word = {3'b000, terms_q.s, terms_q.z, terms_q.p};
    end
  end

  assign out_valid = valid_q;
  assign out_resp  = '{result: result_q, flags: flags_t'(flag_word), set_flags: set_q};

endmodule

`default_nettype wire

/* hw/alu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_top
  import alu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  alu_req_t  in_req,
  input  flags_t    in_flags,
  input  except_t   exc,
  output logic      out_valid,
  output alu_resp_t out_resp
);

  adder_out_t        add_out;
  logic              taken;
  logic [DATA_W-1:0] logic_result;
  logic [DATA_W-1:0] add_result;
  logic [DATA_W-1:0] sel_result;
  logic              use_adder;

  alu_adder u_adder (
    .req (in_req),
    .sum (add_out)
  );

  alu_cond_eval u_cond (
    .flags (in_flags),
    .cond  (in_req.cond),
    .taken (taken)
  );

  alu_logic_unit u_logic (
    .req    (in_req),
    .taken  (taken),
    .result (logic_result)
  );

  assign use_adder = (in_req.op == op_add) || (in_req.op == op_sub);

  // 32-bit add/sub drop the upper half
  assign add_result = in_req.wide ? add_out.sum
                                  : {{(DATA_W-HALF_W){1'b0}}, add_out.sum[HALF_W-1:0]};

  assign sel_result = use_adder ? add_result : logic_result;

  alu_retire u_retire (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (in_req),
    .result    (sel_result),
    .sum       (add_out),
    .exc       (exc),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

endmodule

`default_nettype wire

/* dv/alu_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_asserts
  import alu_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      in_valid,
  input alu_req_t  in_req,
  input logic      out_valid,
  input alu_resp_t out_resp
);

  // output register comes out of reset idle
  a_rst_idle: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  a_valid_src: assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> $past(in_valid)
  ) else $error("out_valid without an op one cycle earlier");

  // only arithmetic and bitwise ops may write flags
  a_flags_src: assert property (
    @(posedge clk) disable iff (rst)
    out_resp.set_flags |-> ($past(in_req.op) inside {op_add, op_sub, op_and, op_or, op_xor})
  ) else $error("set_flags high for a move, extend or conditional op");

endmodule

`default_nettype wire

/* dv/alu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_tb
  import alu_pkg::*;
();

  localparam int          N_OPS      = 1500;
  localparam int          MAX_CYCLES = 2000;
  localparam logic [31:0] SEED       = 32'hd79a_1bbc;

  logic      clk;
  logic      rst;
  logic      in_valid;
  alu_req_t  in_req;
  flags_t    in_flags;
  except_t   exc;
  logic      out_valid;
  alu_resp_t out_resp;

  logic      exp_valid;
  alu_resp_t exp_resp;
  except_t   exc_prev;   // exception seen one edge earlier
  alu_req_t  next_req;
  int        errors = 0;
  int        cycles = 0;

  alu_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .in_flags  (in_flags),
    .exc       (exc),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

  bind alu_top alu_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // even codes are the base condition, odd codes its inverse
  function automatic logic cond_taken(input flags_t f, input cond_e cc);
    logic base;
    case (cc[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.s;
      3'd2:    base = !f.c && !f.z;   // unsigned above
      3'd3:    base = !f.c;
      3'd4:    base = (f.s == f.o) && !f.z;
      3'd5:    base = (f.s == f.o);
      3'd6:    base = f.o;
      default: base = f.p;
    endcase
    return base ^ cc[0];
  endfunction

  function automatic alu_resp_t model_resp(input alu_req_t rq, input flags_t fl);
    alu_resp_t         rsp;
    logic [DATA_W-1:0] mask;
    logic [DATA_W-1:0] ea;
    logic [DATA_W-1:0] eb;
    logic [DATA_W-1:0] r;
    logic [DATA_W:0]   wsum;
    logic              tk;
    int                w;
    rsp  = '0;
    w    = rq.wide ? DATA_W : HALF_W;
    mask = rq.wide ? {DATA_W{1'b1}} : {{(DATA_W-HALF_W){1'b0}}, {HALF_W{1'b1}}};
    ea   = rq.a & mask;
    eb   = rq.b & mask;
    tk   = cond_taken(fl, rq.cond);
    case (rq.op)
      op_add:   r = ea + eb;
      op_sub:   r = ea - eb;
      op_and:   r = ea & eb;
      op_or:    r = ea | eb;
      op_xor:   r = ea ^ eb;
      op_mov:   r = eb;
      op_zxt8:  r = {56'b0, rq.b[7:0]};
      op_zxt16: r = {48'b0, rq.b[15:0]};
      op_sxt8:  r = {{56{rq.b[7]}}, rq.b[7:0]};
      op_sxt16: r = {{48{rq.b[15]}}, rq.b[15:0]};
      op_sxt32: r = {{32{rq.b[31]}}, rq.b[31:0]};
      op_cmov:  r = tk ? rq.b : rq.a;
      op_cset:  r = 64'(tk);
      op_csand: r = 64'(tk & rq.a[0]);
      op_csor:  r = 64'(tk | rq.a[0]);
      default:  r = '0;
    endcase
    r = r & mask;   // narrow forms keep the upper half clear
    rsp.result = r;
    if (rq.op inside {op_add, op_sub, op_and, op_or, op_xor}) begin
      rsp.set_flags = rq.set_flags;
      rsp.flags.s   = r[w-1];
      rsp.flags.z   = (r == '0);
      rsp.flags.p   = ~^r[7:0];
    end
    if (rq.op == op_add) begin
      wsum        = {1'b0, ea} + {1'b0, eb};
      rsp.flags.c = wsum[w];
      rsp.flags.a = ({1'b0, rq.a[3:0]} + {1'b0, rq.b[3:0]}) > 5'd15;
      rsp.flags.o = (ea[w-1] == eb[w-1]) && (r[w-1] != ea[w-1]);
    end else if (rq.op == op_sub) begin
      rsp.flags.c = ea < eb;   // borrow
      rsp.flags.a = rq.a[3:0] < rq.b[3:0];
      rsp.flags.o = (ea[w-1] != eb[w-1]) && (r[w-1] != ea[w-1]);
    end
    return rsp;
  endfunction

  // corner values most of the time
  function automatic logic [DATA_W-1:0] pick_operand();
    case ($urandom_range(0, 7))
      0:       return '0;
      1:       return '1;
      2:       return 64'h7fff_ffff_ffff_ffff;
      3:       return 64'h0000_0000_7fff_ffff;
      4:       return {$urandom, $urandom} | 64'hf;
      default: return {$urandom, $urandom};
    endcase
  endfunction

  // expected response one cycle behind like the DUT
  always @(posedge clk) begin
    if (rst) begin
      exc_prev  <= '0;
      exp_valid <= 1'b0;
      exp_resp  <= '0;
    end else begin
      exc_prev  <= exc;
      exp_valid <= in_valid
                   && !(exc.hit && (exc.thread == in_req.thread))
                   && !(exc_prev.hit && (exc_prev.thread == in_req.thread));
      exp_resp  <= model_resp(in_req, in_flags);
    end
  end

  a_valid: assert property (@(posedge clk) !rst |-> out_valid == exp_valid)
    else begin
      errors++;
      $display("** Error @ %0t: out_valid %0b, expected %0b", $time,
               $sampled(out_valid), $sampled(exp_valid));
    end

  a_resp: assert property (@(posedge clk) !rst && exp_valid |-> out_resp == exp_resp)
    else begin
      errors++;
      $display("** Error @ %0t: result %h flags %b set %b, expected %h flags %b set %b",
               $time, $sampled(out_resp.result), $sampled(out_resp.flags),
               $sampled(out_resp.set_flags), $sampled(exp_resp.result),
               $sampled(exp_resp.flags), $sampled(exp_resp.set_flags));
    end

  a_reset_zero: assert property (@(posedge clk) $fell(rst) |-> out_resp == '0)
    else begin
      errors++;
      $display("** Error @ %0t: out_resp %h not zero after reset", $time,
               $sampled(out_resp));
    end

  initial begin
    void'($urandom(SEED));
    rst      = 1'b1;
    in_valid = 1'b1;   // live op held on the inputs through reset
    in_req   = '0;
    in_req.wide      = 1'b1;
    in_req.set_flags = 1'b1;
    in_req.a         = '1;
    in_flags = '0;
    exc      = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (N_OPS) begin
      @(posedge clk);
      next_req           = '0;
      next_req.op        = alu_op_e'($urandom_range(0, 14));
      next_req.wide      = 1'($urandom_range(0, 1));
      next_req.cond      = cond_e'($urandom_range(0, 15));
      next_req.set_flags = 1'($urandom_range(0, 1));
      next_req.thread    = 1'($urandom_range(0, 1));
      next_req.a         = pick_operand();
      next_req.b         = pick_operand();
      in_valid <= ($urandom_range(0, 9) < 8);
      in_req   <= next_req;
      in_flags <= flags_t'(6'($urandom_range(0, 63)));
      exc      <= '{hit: ($urandom_range(0, 9) == 0), thread: 1'($urandom_range(0, 1))};
    end
    @(posedge clk);
    in_valid <= 1'b0;
    exc      <= '0;
    repeat (3) @(posedge clk);
    $display("run complete, errors: %0d", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      errors = errors + 1;
      $display("timeout: run still going after %0d cycles", MAX_CYCLES);
      $display("run stopped, errors: %0d", errors);
      $display(">>> FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
hw/alu_pkg.sv
hw/alu_adder.sv
hw/alu_cond_eval.sv
hw/alu_logic_unit.sv
hw/alu_retire.sv
hw/alu_top.sv
dv/alu_asserts.sv
dv/alu_tb.sv
